//--- logic/i3c_ccc_settings.svh
/*
  CCC codes, event-enable bit positions and reset values for the target CCC path.
  Only the CCCs listed here are decoded. All other codes are ignored.
*/
`ifndef I3C_CCC_SETTINGS_SVH
`define I3C_CCC_SETTINGS_SVH

// Broadcast CCC codes
`define CCC_ENEC_B    8'h00
`define CCC_DISEC_B   8'h01
`define CCC_RSTDAA_B  8'h06
`define CCC_SETMWL_B  8'h09
`define CCC_SETMRL_B  8'h0A

// Direct CCC codes
`define CCC_ENEC_D    8'h80
`define CCC_DISEC_D   8'h81
`define CCC_SETDASA_D 8'h87
`define CCC_SETMWL_D  8'h89
`define CCC_SETMRL_D  8'h8A

`define I3C_BCAST_ADDR 7'h7E

// Bit positions in the ENEC/DISEC payload byte
`define EVT_IBI_BIT 0
`define EVT_CRR_BIT 1
`define EVT_HJ_BIT  3

`define MWL_RESET 16'd256
`define MRL_RESET 16'd256

`endif

//--- logic/i3c_ccc_pkg.sv
/*
  Shared types for the target CCC path.
  CCC codes below 8'h80 are broadcast, codes from 8'h80 up are direct.
*/
`default_nettype none

package i3c_ccc_pkg;

  // Static or dynamic target address
  typedef logic [6:0] addr7_t;

  // Raw byte from the bus, address bytes carry RnW in bit 0
  typedef logic [7:0] bus_byte_t;

  typedef logic [7:0] ccc_code_t;

  // Maximum write or read length
  typedef logic [15:0] xfer_len_t;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    CODE,
    BCAST_DATA,
    DIRECT_WAIT,
    DIRECT_ADDR,
    DIRECT_DATA,
    IGNORE
  } ccc_state_e;

endpackage

`default_nettype wire

//--- logic/i3c_bus_monitor.sv
/*
  Receive-only I3C bus monitor. SCL and SDA are sampled on clk_i, so each SCL
  phase must last at least 3 clk_i cycles. Every output pulse comes 3 cycles
  after the pin change that causes it. The ninth bit of a byte is not checked.
*/
`default_nettype none

module i3c_bus_monitor (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   scl_i,
  input  logic                   sda_i,
  output logic                   start_o,
  output logic                   rstart_o,
  output logic                   stop_o,
  output logic                   byte_valid_o,
  output logic                   first_o,
  output i3c_ccc_pkg::bus_byte_t byte_o
);
  import i3c_ccc_pkg::*;

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_q;
  logic       sda_q;
  logic       scl_rise;
  logic       start_det;
  logic       stop_det;
  logic       byte_done;
  logic       frame_open_q;
  logic       first_q;
  logic [3:0] bit_cnt_q;
  bus_byte_t  shift_q;

  // Two-flop synchronizer and edge register, idle bus is high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_q      <= scl_sync_q[1];
      sda_q      <= sda_sync_q[1];
    end
  end

  assign scl_rise  = scl_sync_q[1] & ~scl_q;
  assign start_det = scl_sync_q[1] & scl_q & sda_q & ~sda_sync_q[1];
  assign stop_det  = scl_sync_q[1] & scl_q & ~sda_q & sda_sync_q[1];
  assign byte_done = frame_open_q & scl_rise & (bit_cnt_q == 4'd8);

  // Frame state and bit position within the current byte
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_open_q <= 1'b0;
      first_q      <= 1'b0;
      bit_cnt_q    <= 4'd0;
    end else if (start_det) begin
      frame_open_q <= 1'b1;
      first_q      <= 1'b1;
      bit_cnt_q    <= 4'd0;
    end else if (stop_det) begin
      frame_open_q <= 1'b0;
      first_q      <= 1'b0;
      bit_cnt_q    <= 4'd0;
    end else if (byte_done) begin
      first_q   <= 1'b0;
      bit_cnt_q <= 4'd0;
    end else if (frame_open_q && scl_rise) begin
      bit_cnt_q <= bit_cnt_q + 4'd1;
    end
  end

  // MSB first, the ninth bit is skipped
  always_ff @(posedge clk_i) begin
    if (frame_open_q && scl_rise && (bit_cnt_q < 4'd8)) begin
      shift_q <= {shift_q[6:0], sda_sync_q[1]};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_o      <= 1'b0;
      rstart_o     <= 1'b0;
      stop_o       <= 1'b0;
      byte_valid_o <= 1'b0;
      first_o      <= 1'b0;
    end else begin
      start_o      <= start_det & ~frame_open_q;
      rstart_o     <= start_det & frame_open_q;
      stop_o       <= stop_det;
      byte_valid_o <= byte_done;
      first_o      <= byte_done & first_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_done) begin
      byte_o <= shift_q;
    end
  end

endmodule

`default_nettype wire

//--- logic/ccc_decoder.sv
/*
  CCC decoder for the target side. Issues one command pulse per complete CCC,
  one cycle after the last byte. Incomplete or unknown CCCs give no command.
  cmd_code_o and cmd_data_o are only meaningful while cmd_valid_o is high.
*/
`default_nettype none

`include "i3c_ccc_settings.svh"

module ccc_decoder (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   start_i,
  input  logic                   rstart_i,
  input  logic                   stop_i,
  input  logic                   byte_valid_i,
  input  logic                   first_i,
  input  i3c_ccc_pkg::bus_byte_t byte_i,
  input  i3c_ccc_pkg::addr7_t    static_addr_i,
  input  i3c_ccc_pkg::addr7_t    dyn_addr_i,
  input  logic                   dyn_addr_valid_i,
  output logic                   cmd_valid_o,
  output i3c_ccc_pkg::ccc_code_t cmd_code_o,
  output i3c_ccc_pkg::xfer_len_t cmd_data_o
);
  import i3c_ccc_pkg::*;

  ccc_state_e state_q;
  logic       code_kept;
  logic [1:0] code_len;
  logic       two_q;
  logic       got_one_q;
  logic       last_byte;
  logic       addr_match;
  logic       in_data;

  // Payload length of the code on byte_i
  always_comb begin
    code_kept = 1'b0;
    code_len  = 2'd0;
    case (byte_i)
      `CCC_RSTDAA_B: code_kept = 1'b1;
      `CCC_ENEC_B, `CCC_DISEC_B, `CCC_ENEC_D, `CCC_DISEC_D, `CCC_SETDASA_D: begin
        code_kept = 1'b1;
        code_len  = 2'd1;
      end
      `CCC_SETMWL_B, `CCC_SETMRL_B, `CCC_SETMWL_D, `CCC_SETMRL_D: begin
        code_kept = 1'b1;
        code_len  = 2'd2;
      end
      default: ;
    endcase
  end

  // SETDASA answers on the static address, the rest on the dynamic one
  assign addr_match = ~byte_i[0] & ((cmd_code_o == `CCC_SETDASA_D) ?
                      (~dyn_addr_valid_i & (byte_i[7:1] == static_addr_i)) :
                      (dyn_addr_valid_i & (byte_i[7:1] == dyn_addr_i)));

  assign last_byte = got_one_q | ~two_q;
  assign in_data   = (state_q == BCAST_DATA) || (state_q == DIRECT_DATA);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      two_q       <= 1'b0;
      got_one_q   <= 1'b0;
      cmd_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= 1'b0;
      if (stop_i) begin
        state_q <= IDLE;
      end else if (start_i) begin
        state_q <= ADDR;
      end else begin
        case (state_q)
          ADDR: begin
            if (byte_valid_i && first_i) begin
              state_q <= (byte_i == {`I3C_BCAST_ADDR, 1'b0}) ? CODE : IGNORE;
            end
          end
          CODE: begin
            if (rstart_i) begin
              state_q <= ADDR;
            end else if (byte_valid_i) begin
              two_q     <= (code_len == 2'd2);
              got_one_q <= 1'b0;
              if (!code_kept) begin
                state_q <= IGNORE;
              end else if (byte_i[7]) begin
                state_q <= DIRECT_WAIT;
              end else if (code_len == 2'd0) begin
                cmd_valid_o <= 1'b1;
                state_q     <= IGNORE;
              end else begin
                state_q <= BCAST_DATA;
              end
            end
          end
          BCAST_DATA, DIRECT_DATA: begin
            if (rstart_i) begin
              state_q <= (state_q == DIRECT_DATA) ? DIRECT_ADDR : ADDR;
            end else if (byte_valid_i) begin
              got_one_q <= 1'b1;
              if (last_byte) begin
                cmd_valid_o <= 1'b1;
                state_q     <= (state_q == DIRECT_DATA) ? DIRECT_WAIT : IGNORE;
              end
            end
          end
          DIRECT_WAIT: begin
            if (rstart_i) begin
              state_q <= DIRECT_ADDR;
            end
          end
          DIRECT_ADDR: begin
            if (byte_valid_i && first_i) begin
              got_one_q <= 1'b0;
              state_q   <= addr_match ? DIRECT_DATA : DIRECT_WAIT;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Code and payload capture
  always_ff @(posedge clk_i) begin
    if ((state_q == CODE) && byte_valid_i) begin
      cmd_code_o <= byte_i;
    end
    if (in_data && byte_valid_i) begin
      if (got_one_q) begin
        cmd_data_o[7:0] <= byte_i;
      end else begin
        cmd_data_o <= {byte_i, 8'h00};
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ccc_executor.sv
/*
  Target state changed by the kept CCCs. Registers update one cycle after
  cmd_valid_i. Enables reset to 1 and both lengths to 256.
  Commands with codes it does not know are dropped.
*/
`default_nettype none

`include "i3c_ccc_settings.svh"

module ccc_executor (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   cmd_valid_i,
  input  i3c_ccc_pkg::ccc_code_t cmd_code_i,
  input  i3c_ccc_pkg::xfer_len_t cmd_data_i,
  output i3c_ccc_pkg::addr7_t    dyn_addr_o,
  output logic                   dyn_addr_valid_o,
  output logic                   ibi_en_o,
  output logic                   crr_en_o,
  output logic                   hj_en_o,
  output i3c_ccc_pkg::xfer_len_t mwl_o,
  output i3c_ccc_pkg::xfer_len_t mrl_o
);
  import i3c_ccc_pkg::*;

  // One-byte commands carry their byte in the upper half
  bus_byte_t payload;

  assign payload = cmd_data_i[15:8];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dyn_addr_o       <= '0;
      dyn_addr_valid_o <= 1'b0;
      ibi_en_o         <= 1'b1;
      crr_en_o         <= 1'b1;
      hj_en_o          <= 1'b1;
      mwl_o            <= `MWL_RESET;
      mrl_o            <= `MRL_RESET;
    end else if (cmd_valid_i) begin
      case (cmd_code_i)
        `CCC_ENEC_B, `CCC_ENEC_D: begin
          ibi_en_o <= ibi_en_o | payload[`EVT_IBI_BIT];
          crr_en_o <= crr_en_o | payload[`EVT_CRR_BIT];
          hj_en_o  <= hj_en_o | payload[`EVT_HJ_BIT];
        end
        `CCC_DISEC_B, `CCC_DISEC_D: begin
          ibi_en_o <= ibi_en_o & ~payload[`EVT_IBI_BIT];
          crr_en_o <= crr_en_o & ~payload[`EVT_CRR_BIT];
          hj_en_o  <= hj_en_o & ~payload[`EVT_HJ_BIT];
        end
        // Address sits in bits 7:1 of the SETDASA byte
        `CCC_SETDASA_D: begin
          dyn_addr_o       <= payload[7:1];
          dyn_addr_valid_o <= 1'b1;
        end
        `CCC_RSTDAA_B: dyn_addr_valid_o <= 1'b0;
        `CCC_SETMWL_B, `CCC_SETMWL_D: mwl_o <= cmd_data_i;
        `CCC_SETMRL_B, `CCC_SETMRL_D: mrl_o <= cmd_data_i;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/i3c_target_ccc.sv
/*
  Receive-only I3C target CCC path. SDA is never driven, ACK and T-bits
  must come from outside. Each SCL phase needs at least 3 clk_i cycles.
  State outputs change 5 cycles after the ninth SCL rise of a command's last byte.
*/
`default_nettype none

module i3c_target_ccc (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   scl_i,
  input  logic                   sda_i,
  input  i3c_ccc_pkg::addr7_t    static_addr_i,
  output logic                   bus_start_o,
  output logic                   bus_rstart_o,
  output logic                   bus_stop_o,
  output i3c_ccc_pkg::bus_byte_t bus_addr_o,
  output logic                   bus_addr_valid_o,
  output i3c_ccc_pkg::addr7_t    dyn_addr_o,
  output logic                   dyn_addr_valid_o,
  output logic                   ibi_en_o,
  output logic                   crr_en_o,
  output logic                   hj_en_o,
  output i3c_ccc_pkg::xfer_len_t mwl_o,
  output i3c_ccc_pkg::xfer_len_t mrl_o
);
  import i3c_ccc_pkg::*;

  logic      byte_valid;
  logic      cmd_valid;
  ccc_code_t cmd_code;
  xfer_len_t cmd_data;

  // First byte after START or Sr is the address byte
  i3c_bus_monitor u_bus_monitor (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .scl_i        (scl_i),
    .sda_i        (sda_i),
    .start_o      (bus_start_o),
    .rstart_o     (bus_rstart_o),
    .stop_o       (bus_stop_o),
    .byte_valid_o (byte_valid),
    .first_o      (bus_addr_valid_o),
    .byte_o       (bus_addr_o)
  );

  ccc_decoder u_ccc_decoder (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .start_i          (bus_start_o),
    .rstart_i         (bus_rstart_o),
    .stop_i           (bus_stop_o),
    .byte_valid_i     (byte_valid),
    .first_i          (bus_addr_valid_o),
    .byte_i           (bus_addr_o),
    .static_addr_i    (static_addr_i),
    .dyn_addr_i       (dyn_addr_o),
    .dyn_addr_valid_i (dyn_addr_valid_o),
    .cmd_valid_o      (cmd_valid),
    .cmd_code_o       (cmd_code),
    .cmd_data_o       (cmd_data)
  );

  ccc_executor u_ccc_executor (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cmd_valid_i      (cmd_valid),
    .cmd_code_i       (cmd_code),
    .cmd_data_i       (cmd_data),
    .dyn_addr_o       (dyn_addr_o),
    .dyn_addr_valid_o (dyn_addr_valid_o),
    .ibi_en_o         (ibi_en_o),
    .crr_en_o         (crr_en_o),
    .hj_en_o          (hj_en_o),
    .mwl_o            (mwl_o),
    .mrl_o            (mrl_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_rst_gen.sv
/*
  40 ns clock. Reset is held low for the first 3 rising edges.
*/
`default_nettype none

module tb_clk_rst_gen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/i3c_target_ccc_asserts.sv
/*
  Concurrent checks on the bus and address outputs of the top level.
  Bound to every i3c_target_ccc instance.
*/
`default_nettype none

module i3c_target_ccc_asserts (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                bus_start_i,
  input logic                bus_rstart_i,
  input logic                bus_stop_i,
  input logic                bus_addr_valid_i,
  input i3c_ccc_pkg::addr7_t dyn_addr_i,
  input logic                dyn_addr_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic addr_pending_q;
  logic was_valid_q;

  // One address byte per START or Sr
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_pending_q <= 1'b0;
      was_valid_q    <= 1'b0;
    end else begin
      if (bus_start_i || bus_rstart_i) begin
        addr_pending_q <= 1'b1;
      end else if (bus_addr_valid_i) begin
        addr_pending_q <= 1'b0;
      end
      // Valid only falls on RSTDAA
      if (dyn_addr_valid_i) begin
        was_valid_q <= 1'b1;
      end
    end
  end

  start_stop_apart: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(bus_start_i && bus_stop_i))
    else $error("START and STOP pulses in the same cycle");

  addr_after_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_addr_valid_i |-> addr_pending_q)
    else $error("Address byte without a preceding START or repeated START");

  valid_rise_reason: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(dyn_addr_valid_i) |-> ((dyn_addr_i != $past(dyn_addr_i)) || was_valid_q))
    else $error("Dynamic address became valid without a new address or a prior RSTDAA");

endmodule

bind i3c_target_ccc i3c_target_ccc_asserts u_asserts (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .bus_start_i      (bus_start_o),
  .bus_rstart_i     (bus_rstart_o),
  .bus_stop_i       (bus_stop_o),
  .bus_addr_valid_i (bus_addr_valid_o),
  .dyn_addr_i       (dyn_addr_o),
  .dyn_addr_valid_i (dyn_addr_valid_o)
);

`default_nettype wire

//--- testbench/tb_i3c_target_ccc.sv
/*
  Directed tests for the receive-only target CCC path. The testbench acts as
  the controller and drives ACK and T-bits high itself. 4 clk cycles per SCL phase.
*/
`default_nettype none

`include "i3c_ccc_settings.svh"

module tb_i3c_target_ccc;
  timeunit 1ns;
  timeprecision 1ps;

  import i3c_ccc_pkg::*;

  logic        clk;
  logic        arst_n;
  logic        scl;
  logic        sda;
  addr7_t      static_addr;
  logic        start_pulse;
  logic        rstart_pulse;
  logic        stop_pulse;
  bus_byte_t   bus_addr;
  logic        bus_addr_valid;
  addr7_t      dyn_addr;
  logic        dyn_addr_valid;
  logic        ibi_en;
  logic        crr_en;
  logic        hj_en;
  xfer_len_t   mwl;
  xfer_len_t   mrl;

  // Expected target state
  logic        exp_ibi;
  logic        exp_crr;
  logic        exp_hj;
  logic        exp_dav;
  addr7_t      exp_da;
  xfer_len_t   exp_mwl;
  xfer_len_t   exp_mrl;

  logic [31:0] rng_state;
  int          checks;
  int          errors;
  int          timeouts;
  int          start_cnt = 0;
  int          rstart_cnt = 0;
  int          stop_cnt = 0;
  bus_byte_t   addr_q[$];

  tb_clk_rst_gen u_clk_rst_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  i3c_target_ccc u_dut (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .scl_i            (scl),
    .sda_i            (sda),
    .static_addr_i    (static_addr),
    .bus_start_o      (start_pulse),
    .bus_rstart_o     (rstart_pulse),
    .bus_stop_o       (stop_pulse),
    .bus_addr_o       (bus_addr),
    .bus_addr_valid_o (bus_addr_valid),
    .dyn_addr_o       (dyn_addr),
    .dyn_addr_valid_o (dyn_addr_valid),
    .ibi_en_o         (ibi_en),
    .crr_en_o         (crr_en),
    .hj_en_o          (hj_en),
    .mwl_o            (mwl),
    .mrl_o            (mrl)
  );

  // Bus events and address bytes reported by the DUT
  always @(posedge clk) begin
    if (start_pulse) start_cnt <= start_cnt + 1;
    if (rstart_pulse) rstart_cnt <= rstart_cnt + 1;
    if (stop_pulse) stop_cnt <= stop_cnt + 1;
    if (bus_addr_valid) addr_q.push_back(bus_addr);
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check(input string name, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("ERROR %s: expected %0h, actual %0h", name, exp_val, act_val);
    end
  endtask

  task automatic check_state(input string test);
    check({test, " ibi_en"}, 32'(exp_ibi), 32'(ibi_en));
    check({test, " crr_en"}, 32'(exp_crr), 32'(crr_en));
    check({test, " hj_en"}, 32'(exp_hj), 32'(hj_en));
    check({test, " mwl"}, 32'(exp_mwl), 32'(mwl));
    check({test, " mrl"}, 32'(exp_mrl), 32'(mrl));
    check({test, " dyn_addr_valid"}, 32'(exp_dav), 32'(dyn_addr_valid));
    if (exp_dav) check({test, " dyn_addr"}, 32'(exp_da), 32'(dyn_addr));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_reset();
    for (int i = 0; i < 10 && !arst_n; i++) @(posedge clk);
    if (!arst_n) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    wait_cycles(2);
  endtask

  task automatic bus_start();
    @(posedge clk);
    sda <= 1'b0;
    wait_cycles(4);
    scl <= 1'b0;
  endtask

  task automatic bus_rstart();
    wait_cycles(1);
    sda <= 1'b1;
    wait_cycles(3);
    scl <= 1'b1;
    wait_cycles(4);
    sda <= 1'b0;
    wait_cycles(4);
    scl <= 1'b0;
  endtask

  // SDA changes one cycle after SCL falls
  task automatic bus_byte(input bus_byte_t b);
    logic [8:0] bits;
    bits = {b, 1'b1};
    for (int i = 0; i < 9; i++) begin
      wait_cycles(1);
      sda <= bits[8];
      bits = bits << 1;
      wait_cycles(3);
      scl <= 1'b1;
      wait_cycles(4);
      scl <= 1'b0;
    end
  endtask

  task automatic bus_stop();
    logic seen;
    seen = 1'b0;
    wait_cycles(1);
    sda <= 1'b0;
    wait_cycles(3);
    scl <= 1'b1;
    wait_cycles(4);
    sda <= 1'b1;
    for (int i = 0; i < 16 && !seen; i++) begin
      @(posedge clk);
      seen = stop_pulse;
    end
    if (!seen) begin
      timeouts++;
      $display("Timeout: the DUT reported no STOP after the bus was released");
    end
    wait_cycles(2);
  endtask

  task automatic send_payload(input int len, input xfer_len_t data);
    if (len > 0) bus_byte(data[15:8]);
    if (len > 1) bus_byte(data[7:0]);
  endtask

  task automatic bcast_ccc(input ccc_code_t code, input int len, input xfer_len_t data);
    bus_start();
    bus_byte({`I3C_BCAST_ADDR, 1'b0});
    bus_byte(code);
    send_payload(len, data);
    bus_stop();
  endtask

  task automatic direct_ccc(input ccc_code_t code, input addr7_t target, input int len,
                            input xfer_len_t data);
    bus_start();
    bus_byte({`I3C_BCAST_ADDR, 1'b0});
    bus_byte(code);
    bus_rstart();
    bus_byte({target, 1'b0});
    send_payload(len, data);
    bus_stop();
  endtask

  task automatic expect_enec(input bus_byte_t mask);
    exp_ibi = exp_ibi | mask[`EVT_IBI_BIT];
    exp_crr = exp_crr | mask[`EVT_CRR_BIT];
    exp_hj  = exp_hj | mask[`EVT_HJ_BIT];
  endtask

  task automatic expect_disec(input bus_byte_t mask);
    exp_ibi = exp_ibi & ~mask[`EVT_IBI_BIT];
    exp_crr = exp_crr & ~mask[`EVT_CRR_BIT];
    exp_hj  = exp_hj & ~mask[`EVT_HJ_BIT];
  endtask

  task automatic event_test();
    logic [31:0] rnd;
    bus_byte_t   mask;
    for (int i = 0; i < 4; i++) begin
      rnd = next_random();
      mask = rnd[7:0];
      bcast_ccc(`CCC_DISEC_B, 1, {mask, 8'h00});
      expect_disec(mask);
      check_state("bcast disec");
      mask = rnd[15:8];
      bcast_ccc(`CCC_ENEC_B, 1, {mask, 8'h00});
      expect_enec(mask);
      check_state("bcast enec");
    end
  endtask

  task automatic dasa_test();
    direct_ccc(`CCC_SETDASA_D, 7'h21, 1, {7'h52, 1'b0, 8'h00});
    check_state("setdasa other");
    direct_ccc(`CCC_SETDASA_D, static_addr, 1, {7'h52, 1'b0, 8'h00});
    exp_da = 7'h52;
    exp_dav = 1'b1;
    check_state("setdasa match");
    bcast_ccc(`CCC_RSTDAA_B, 0, 16'h0000);
    exp_dav = 1'b0;
    check_state("rstdaa");
    direct_ccc(`CCC_SETDASA_D, static_addr, 1, {7'h2C, 1'b0, 8'h00});
    exp_da = 7'h2C;
    exp_dav = 1'b1;
    check_state("setdasa again");
  endtask

  task automatic length_test();
    logic [31:0] rnd;
    rnd = next_random();
    bcast_ccc(`CCC_SETMWL_B, 2, rnd[15:0]);
    exp_mwl = rnd[15:0];
    check_state("bcast setmwl");
    direct_ccc(`CCC_SETMRL_D, exp_da, 2, rnd[31:16]);
    exp_mrl = rnd[31:16];
    check_state("direct setmrl");
    // Stopped after the first payload byte
    bcast_ccc(`CCC_SETMWL_B, 1, 16'h1234);
    check_state("short setmwl");
  endtask

  task automatic monitor_test();
    int starts;
    int rstarts;
    int stops;
    int base;
    starts = start_cnt;
    rstarts = rstart_cnt;
    stops = stop_cnt;
    base = addr_q.size();
    // Looks like a SETMWL if the address were taken as broadcast
    bus_start();
    bus_byte({7'h15, 1'b0});
    bus_byte(`CCC_SETMWL_B);
    bus_byte(8'hA5);
    bus_byte(8'h5A);
    bus_stop();
    check_state("private write");
    direct_ccc(`CCC_SETMWL_D, exp_da, 2, 16'h0140);
    exp_mwl = 16'h0140;
    check_state("direct setmwl");
    check("start count", starts + 2, start_cnt);
    check("rstart count", rstarts + 1, rstart_cnt);
    check("stop count", stops + 2, stop_cnt);
    check("addr count", base + 3, addr_q.size());
    if (addr_q.size() == base + 3) begin
      check("addr private", 32'({7'h15, 1'b0}), 32'(addr_q[base]));
      check("addr bcast", 32'({`I3C_BCAST_ADDR, 1'b0}), 32'(addr_q[base + 1]));
      check("addr direct", 32'({exp_da, 1'b0}), 32'(addr_q[base + 2]));
    end
  endtask

  task automatic direct_event_test();
    bcast_ccc(`CCC_DISEC_B, 1, 16'h0B00);
    expect_disec(8'h0B);
    check_state("bcast disec all");
    direct_ccc(`CCC_ENEC_D, exp_da ^ 7'h01, 1, 16'h0B00);
    check_state("direct enec other");
    bcast_ccc(`CCC_ENEC_B, 1, 16'h0B00);
    expect_enec(8'h0B);
    check_state("bcast enec all");
    direct_ccc(`CCC_DISEC_D, exp_da, 1, 16'h0B00);
    expect_disec(8'h0B);
    check_state("direct disec match");
  endtask

  initial begin
    scl = 1'b1;
    sda = 1'b1;
    static_addr = 7'h3A;
    rng_state = 32'h25db_ec68;
    checks = 0;
    errors = 0;
    timeouts = 0;
    exp_ibi = 1'b1;
    exp_crr = 1'b1;
    exp_hj = 1'b1;
    exp_dav = 1'b0;
    exp_da = 7'h00;
    exp_mwl = `MWL_RESET;
    exp_mrl = `MRL_RESET;
    wait_reset();
    check_state("reset");
    event_test();
    dasa_test();
    length_test();
    monitor_test();
    direct_event_test();
    $display("Closing: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/i3c_ccc_pkg.sv
logic/i3c_bus_monitor.sv
logic/ccc_decoder.sv
logic/ccc_executor.sv
logic/i3c_target_ccc.sv
testbench/tb_clk_rst_gen.sv
testbench/i3c_target_ccc_asserts.sv
testbench/tb_i3c_target_ccc.sv

//--- Makefile
TOP := tb_i3c_target_ccc

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
